//--- sources.f
+incdir+hw
hw/rgmii_rx_pkg.sv
hw/rgmii_ddr_capture.sv
hw/rgmii_inband_status.sv
hw/rgmii_frame_rx.sv
hw/eth_crc32_check.sv
hw/rgmii_rx_top.sv
testbench/tb_rgmii_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the RGMII receive testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
	-f sources.f \
	--top-module tb_rgmii_rx \
	-o tb_rgmii_rx

./obj_dir/tb_rgmii_rx | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished, log in sim.log"

//--- testbench/tb_rgmii_rx.sv
`include "rgmii_rx_consts.svh"

module tb_rgmii_rx;

	timeunit 1ns;
	timeprecision 1ps;

	logic                        rx_clk = 1'b0;
	logic                        rst_n;
	logic                        rx_ctl;
	logic [3:0]                  rx_data;
	rgmii_rx_pkg::link_status_t  link;
	rgmii_rx_pkg::frame_beat_t   beat;
	rgmii_rx_pkg::frame_result_t result;

	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int beat_count = 0;
	int done_count = 0;

	logic [3:0]                  cur_status;  // Nibble the PHY repeats between frames
	logic [7:0]                  payload_q[$];
	logic [8:0]                  exp_q[$];    // Expected {sof, data} per beat
	logic [8:0]                  exp_now;
	logic                        exp_avail;
	logic                        link_hold;   // Link must stay at link_expect while set
	rgmii_rx_pkg::link_status_t  link_expect;
	rgmii_rx_pkg::link_status_t  link_seen;
	rgmii_rx_pkg::frame_result_t last_result;

	always #50 rx_clk = ~rx_clk;

	rgmii_rx_top u_dut (
		.rx_clk  (rx_clk),
		.rst_n   (rst_n),
		.rx_ctl  (rx_ctl),
		.rx_data (rx_data),
		.link    (link),
		.beat    (beat),
		.result  (result)
	);

	// ****************************************
	// Monitor and assertions
	// ****************************************

	// Outputs only change on the rising edge, so the falling edge sees them settled
	always @(negedge rx_clk) begin
		exp_avail = (exp_q.size() > 0);
		exp_now   = exp_avail ? exp_q[0] : 9'h0;
		if (rst_n && beat.valid) begin
			beat_count++;
			if (exp_avail)
				void'(exp_q.pop_front());
		end
		if (rst_n && result.done) begin
			done_count++;
			last_result = result;
		end
		link_seen = link;
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n) beat.valid |-> exp_avail)
	else begin
		errors++;
		$display("A beat came out while no frame byte was pending");
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n)
		beat.valid && exp_avail |-> {beat.sof, beat.data} == exp_now)
	else begin
		errors++;
		$display("Error beat {sof, data}: expected 0x%03h got 0x%03h",
			$sampled(exp_now), $sampled({beat.sof, beat.data}));
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n) result.done |=> !result.done)
	else begin
		errors++;
		$display("The done pulse lasted more than one cycle");
	end

	// Bytes with dv high are never status bytes
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		u_dut.rx_byte.dv |=> $stable(link))
	else begin
		errors++;
		$display("Link status changed while a frame was on the wire");
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n) link_hold |-> link == link_expect)
	else begin
		errors++;
		$display("Error link: expected 0x%02h got 0x%02h",
			$sampled(link_expect), $sampled(link));
	end

	// ****************************************
	// Helpers
	// ****************************************

	// Reflected CRC-32 taken one data bit at a time with the LSB first
	function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] d);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int b = 0; b < 8; b++) begin
			fb = c[0] ^ d[b];
			c  = c >> 1;
			if (fb)
				c = c ^ `CRC32_POLY;
		end
		return c;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] want,
		input logic [31:0] got);
		assert (want == got) else begin
			errors++;
			$display("Error %s: expected 0x%0h got 0x%0h", name, want, got);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_passed++;
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", name, errors - err_start);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Summary: passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		$display("Test failed");
		$finish;
	endtask

	// Low nibble is set up ahead of the rising edge and the high nibble ahead of the falling edge
	task automatic send_byte(input logic [7:0] d, input logic dv, input logic er);
		@(negedge rx_clk);
		rx_data <= d[3:0];
		rx_ctl  <= dv;
		@(posedge rx_clk);
		rx_data <= d[7:4];
		rx_ctl  <= dv ^ er; // Second control half carries dv xor er
	endtask

	task automatic send_idle();
		send_byte({cur_status, cur_status}, 1'b0, 1'b0);
	endtask

	task automatic wait_link(input rgmii_rx_pkg::link_status_t want);
		int n;
		n = 0;
		while (link_seen != want && n < 20) begin
			send_idle();
			n++;
		end
		if (link_seen != want)
			abort_run($sformatf("Timeout: link never reached 0x%02h and is still 0x%02h",
				want, link_seen));
	endtask

	task automatic make_payload(output int len);
		len = 46 + int'($urandom % 55);
		payload_q.delete();
		repeat (len) payload_q.push_back(8'($urandom));
	endtask

	// err_at picks the frame byte sent with er and is -1 for none
	task automatic send_frame(input logic bad_fcs, input int err_at);
		logic [31:0] crc;
		logic [31:0] fcs;
		logic [7:0]  frame[$];
		crc = 32'hFFFF_FFFF;
		foreach (payload_q[i])
			crc = crc_next(crc, payload_q[i]);
		fcs = ~crc;
		if (bad_fcs)
			fcs = fcs ^ (32'h1 << ($urandom % 32));
		frame = payload_q;
		for (int k = 0; k < 4; k++)
			frame.push_back(fcs[8*k +: 8]); // FCS goes out least significant byte first
		foreach (frame[i])
			exp_q.push_back({i == 0, frame[i]});
		repeat (7) send_byte(`RGMII_PREAMBLE, 1'b1, 1'b0);
		send_byte(`RGMII_SFD, 1'b1, 1'b0);
		foreach (frame[i])
			send_byte(frame[i], 1'b1, i == err_at);
	endtask

	task automatic collect_result(input int done_before);
		int n;
		n = 0;
		while (done_count == done_before && n < 40) begin
			send_idle();
			n++;
		end
		if (done_count == done_before) begin
			abort_run("Timeout: no frame result came after the frame ended");
		end else begin
			repeat (3) send_idle();
			expect_equal("result.done pulse count", 32'(done_before + 1), 32'(done_count));
			if (exp_q.size() != 0) begin
				errors++;
				$display("%0d frame bytes never appeared on the beat output", exp_q.size());
				exp_q.delete();
			end
		end
	endtask

	task automatic check_result(input logic want_ok, input logic want_err, input int want_len);
		expect_equal("result.crc_ok", 32'(want_ok), 32'(last_result.crc_ok));
		expect_equal("result.rx_error", 32'(want_err), 32'(last_result.rx_error));
		expect_equal("result.length", 32'(want_len), 32'(last_result.length));
	endtask

	// ****************************************
	// Test sequence
	// ****************************************

	initial begin
		int                         err_start;
		int                         len;
		int                         beats_before;
		int                         done_before;
		rgmii_rx_pkg::link_status_t want;

		rst_n       = 1'b0;
		rx_ctl      = 1'b0;
		rx_data     = 4'h0;
		cur_status  = 4'h0;
		link_hold   = 1'b0;
		link_expect = '0;
		void'($urandom(32'hb7f92000));
		repeat (3) @(posedge rx_clk);
		rst_n <= 1'b1;

		err_start = errors;
		@(negedge rx_clk);
		expect_equal("beat.valid", 32'h0, 32'(beat.valid));
		expect_equal("result.done", 32'h0, 32'(result.done));
		expect_equal("link.link_up", 32'h0, 32'(link.link_up));
		expect_equal("link.speed", 32'(rgmii_rx_pkg::speed_none), 32'(link.speed));
		finish_test("reset", err_start);

		err_start = errors;
		for (int dup = 0; dup < 2; dup++) begin
			for (int sp = 0; sp < 3; sp++) begin
				cur_status       = {dup[0], sp[1:0], 1'b1};
				want.link_up     = 1'b1;
				want.speed       = rgmii_rx_pkg::link_speed_t'(sp[1:0]);
				want.full_duplex = dup[0];
				wait_link(want);
			end
		end
		link_expect = want;
		link_hold   = 1'b1;
		send_byte({cur_status, cur_status ^ 4'b1010}, 1'b0, 1'b0);
		send_byte({cur_status ^ 4'b0110, cur_status}, 1'b0, 1'b0);
		repeat (4) send_idle();
		link_hold = 1'b0;
		finish_test("in-band status", err_start);

		err_start   = errors;
		done_before = done_count;
		make_payload(len);
		send_frame(1'b0, -1);
		collect_result(done_before);
		check_result(1'b1, 1'b0, len + 4);
		finish_test("good frame", err_start);

		err_start   = errors;
		done_before = done_count;
		send_frame(1'b1, -1); // Same payload with one FCS bit flipped
		collect_result(done_before);
		check_result(1'b0, 1'b0, len + 4);
		finish_test("bad FCS", err_start);

		err_start   = errors;
		done_before = done_count;
		link_expect = want;
		link_hold   = 1'b1;
		repeat (3) send_idle();
		make_payload(len);
		send_frame(1'b0, 10);
		collect_result(done_before);
		check_result(1'b1, 1'b1, len + 4);
		link_hold = 1'b0;
		finish_test("receive error", err_start);

		err_start    = errors;
		beats_before = beat_count;
		done_before  = done_count;
		repeat (4) send_byte(`RGMII_PREAMBLE, 1'b1, 1'b0);
		send_byte(8'h12, 1'b1, 1'b0);
		send_byte(`RGMII_SFD, 1'b1, 1'b0); // The search has already restarted by now
		repeat (6) send_byte(8'hA3, 1'b1, 1'b0);
		repeat (8) send_idle();
		expect_equal("beat.valid count", 32'(beats_before), 32'(beat_count));
		expect_equal("result.done count", 32'(done_before), 32'(done_count));
		make_payload(len);
		send_frame(1'b0, -1);
		collect_result(done_before);
		check_result(1'b1, 1'b0, len + 4);
		finish_test("broken preamble", err_start);

		$display("Summary: passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- hw/rgmii_rx_top.sv
module rgmii_rx_top (
	input  logic                        rx_clk,
	input  logic                        rst_n,
	input  logic                        rx_ctl,
	input  logic [3:0]                  rx_data,
	output rgmii_rx_pkg::link_status_t  link,
	output rgmii_rx_pkg::frame_beat_t   beat,
	output rgmii_rx_pkg::frame_result_t result
);

	// ****************************************
	// Internal wiring
	// ****************************************

	rgmii_rx_pkg::rx_byte_t rx_byte; // Shared by the status decoder and the frame receiver
	logic                   frame_end;
	logic                   frame_error;

	rgmii_ddr_capture u_capture (
		.rx_clk  (rx_clk),
		.rst_n   (rst_n),
		.rx_ctl  (rx_ctl),
		.rx_data (rx_data),
		.rx_byte (rx_byte)
	);

	// Sees only the inter-frame bytes
	rgmii_inband_status u_status (
		.rx_clk  (rx_clk),
		.rst_n   (rst_n),
		.rx_byte (rx_byte),
		.link    (link)
	);

	rgmii_frame_rx u_frame (
		.rx_clk      (rx_clk),
		.rst_n       (rst_n),
		.rx_byte     (rx_byte),
		.beat        (beat),
		.frame_end   (frame_end),
		.frame_error (frame_error)
	);

	// Taps the same beats that leave the top
	eth_crc32_check u_crc (
		.rx_clk      (rx_clk),
		.rst_n       (rst_n),
		.beat        (beat),
		.frame_end   (frame_end),
		.frame_error (frame_error),
		.result      (result)
	);

endmodule

//--- hw/eth_crc32_check.sv
`include "rgmii_rx_consts.svh"

module eth_crc32_check (
	input  logic                        rx_clk,
	input  logic                        rst_n,
	input  rgmii_rx_pkg::frame_beat_t   beat,
	input  logic                        frame_end,
	input  logic                        frame_error,
	output rgmii_rx_pkg::frame_result_t result
);

	// One byte of the reflected CRC, data shifted in LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc ^ {24'h0, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ `CRC32_POLY) : (c >> 1);
		end
		return c;
	endfunction

	// ****************************************
	// CRC register and byte count
	// ****************************************

	logic [31:0]             crc_q;
	logic [`FRAME_LEN_W-1:0] len_q;

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			crc_q <= 32'hFFFF_FFFF;
			len_q <= '0;
		end else if (beat.valid) begin
			if (beat.sof) begin
				crc_q <= crc_byte(32'hFFFF_FFFF, beat.data); // New frame starts from all ones
				len_q <= `FRAME_LEN_W'(1);
			end else begin
				crc_q <= crc_byte(crc_q, beat.data);
				len_q <= len_q + 1'b1;
			end
		end
	end

	// ****************************************
	// Result at frame end
	// ****************************************

	logic                    done_q;
	logic                    crc_ok_q;
	logic                    rx_error_q;
	logic [`FRAME_LEN_W-1:0] length_q;

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else begin
			done_q <= frame_end;
		end
	end

	// Fields are held until the next frame ends
	always_ff @(posedge rx_clk) begin
		if (frame_end) begin
			crc_ok_q   <= (crc_q == `CRC32_RESIDUE);
			rx_error_q <= frame_error;
			length_q   <= len_q;
		end
	end

	assign result = '{done: done_q, crc_ok: crc_ok_q, rx_error: rx_error_q, length: length_q};

endmodule

//--- hw/rgmii_frame_rx.sv
`include "rgmii_rx_consts.svh"

module rgmii_frame_rx (
	input  logic                      rx_clk,
	input  logic                      rst_n,
	input  rgmii_rx_pkg::rx_byte_t    rx_byte,
	output rgmii_rx_pkg::frame_beat_t beat,
	output logic                      frame_end,
	output logic                      frame_error
);

	typedef enum logic [1:0] {
		st_idle,
		st_preamble,
		st_data
	} state_t;

	state_t state_q;

	logic       first_q; // Next data byte is the first of the frame
	logic       err_q;   // Sticky over the whole frame
	logic [7:0] beat_data_q;
	logic       beat_valid_q;
	logic       beat_sof_q;
	logic       frame_end_q;
	logic       frame_error_q;

	// ****************************************
	// Preamble and SFD search
	// ****************************************

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state_q       <= st_idle;
			first_q       <= 1'b0;
			err_q         <= 1'b0;
			beat_valid_q  <= 1'b0;
			beat_sof_q    <= 1'b0;
			frame_end_q   <= 1'b0;
			frame_error_q <= 1'b0;
		end else begin
			beat_valid_q  <= 1'b0;
			beat_sof_q    <= 1'b0;
			frame_end_q   <= 1'b0;
			frame_error_q <= 1'b0;

			case (state_q)
				st_idle: begin
					if (rx_byte.dv && rx_byte.data == `RGMII_PREAMBLE) begin
						state_q <= st_preamble;
					end
				end

				st_preamble: begin
					if (!rx_byte.dv) begin
						state_q <= st_idle; // Carrier lost before the SFD
					end else if (rx_byte.data == `RGMII_SFD) begin
						state_q <= st_data;
						first_q <= 1'b1;
						err_q   <= rx_byte.er;
					end else if (rx_byte.data != `RGMII_PREAMBLE) begin
						state_q <= st_idle;
					end
				end

				st_data: begin
					if (rx_byte.dv) begin
						beat_valid_q <= 1'b1;
						beat_sof_q   <= first_q;
						first_q      <= 1'b0;
						if (rx_byte.er) begin
							err_q <= 1'b1;
						end
					end else begin
						// End of carrier closes the frame
						frame_end_q   <= 1'b1;
						frame_error_q <= err_q;
						state_q       <= st_idle;
					end
				end

				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// ****************************************
	// Beat payload
	// ****************************************

	always_ff @(posedge rx_clk) begin
		beat_data_q <= rx_byte.data;
	end

	assign beat = '{data: beat_data_q, valid: beat_valid_q, sof: beat_sof_q};

	assign frame_end   = frame_end_q;
	assign frame_error = frame_error_q;

endmodule

//--- hw/rgmii_inband_status.sv
module rgmii_inband_status (
	input  logic                       rx_clk,
	input  logic                       rst_n,
	input  rgmii_rx_pkg::rx_byte_t     rx_byte,
	output rgmii_rx_pkg::link_status_t link
);

	// ****************************************
	// Status byte recognition
	// ****************************************

	// Between frames the PHY repeats the status nibble in both halves
	logic qualify;

	assign qualify = !rx_byte.dv && !rx_byte.er &&
		(rx_byte.data[3:0] == rx_byte.data[7:4]);

	rgmii_rx_pkg::link_status_t decoded;

	always_comb begin
		decoded.speed       = rgmii_rx_pkg::link_speed_t'(rx_byte.data[2:1]);
		decoded.link_up     = rx_byte.data[0];
		decoded.full_duplex = rx_byte.data[3];
		// Reserved speed code is treated as no link
		if (rx_byte.data[2:1] == 2'b11) begin
			decoded.link_up = 1'b0;
		end
		if (!decoded.link_up) begin
			decoded.speed       = rgmii_rx_pkg::speed_none;
			decoded.full_duplex = 1'b0;
		end
	end

	// ****************************************
	// Held link state
	// ****************************************

	rgmii_rx_pkg::link_status_t link_q;

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			link_q.link_up     <= 1'b0;
			link_q.speed       <= rgmii_rx_pkg::speed_none;
			link_q.full_duplex <= 1'b0;
		end else if (qualify) begin
			link_q <= decoded;
		end
	end

	assign link = link_q; // Frame bytes and odd bytes leave the last value

endmodule

//--- hw/rgmii_ddr_capture.sv
module rgmii_ddr_capture (
	input  logic                  rx_clk,
	input  logic                  rst_n,
	input  logic                  rx_ctl,
	input  logic [3:0]            rx_data,
	output rgmii_rx_pkg::rx_byte_t rx_byte
);

	// ****************************************
	// Input sampling on both edges
	// ****************************************

	logic [3:0] lo_q;       // Low nibble, rising edge
	logic       ctl_rise_q; // RX_DV
	logic [3:0] hi_q;       // High nibble, falling edge
	logic       ctl_fall_q; // RX_DV xor RX_ER

	always_ff @(posedge rx_clk) begin
		lo_q       <= rx_data;
		ctl_rise_q <= rx_ctl;
	end

	always_ff @(negedge rx_clk) begin
		hi_q       <= rx_data;
		ctl_fall_q <= rx_ctl;
	end

	// ****************************************
	// Same-edge alignment
	// ****************************************

	// Both halves of the byte were taken since the last rising edge,
	// so they are moved together into the rising-edge domain here
	logic [7:0] data_q;
	logic       dv_q;
	logic       er_q;

	always_ff @(posedge rx_clk) begin
		data_q <= {hi_q, lo_q};
	end

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			dv_q <= 1'b0;
			er_q <= 1'b0;
		end else begin
			dv_q <= ctl_rise_q;
			er_q <= ctl_rise_q ^ ctl_fall_q; // Second control sample carries dv xor er
		end
	end

	assign rx_byte = '{data: data_q, dv: dv_q, er: er_q};

endmodule

//--- hw/rgmii_rx_pkg.sv
`include "rgmii_rx_consts.svh"

package rgmii_rx_pkg;

	// ****************************************
	// Link status from the in-band PHY bytes
	// ****************************************

	// Codes follow the bits 2:1 of the RGMII status byte
	typedef enum logic [1:0] {
		speed_10   = 2'b00,
		speed_100  = 2'b01,
		speed_1000 = 2'b10,
		speed_none = 2'b11
	} link_speed_t;

	typedef struct packed {
		logic        link_up;
		link_speed_t speed;
		logic        full_duplex;
	} link_status_t;

	// ****************************************
	// Byte streams
	// ****************************************

	// One byte rebuilt from the two DDR nibbles
	typedef struct packed {
		logic [7:0] data;
		logic       dv; // Receive data valid
		logic       er; // Receive error
	} rx_byte_t;

	// Frame byte with preamble and SFD stripped
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       sof; // First byte after the SFD
	} frame_beat_t;

	typedef struct packed {
		logic                    done;
		logic                    crc_ok;
		logic                    rx_error;
		logic [`FRAME_LEN_W-1:0] length; // Bytes after the SFD, FCS included
	} frame_result_t;

endpackage

//--- hw/rgmii_rx_consts.svh
`ifndef RGMII_RX_CONSTS_SVH
`define RGMII_RX_CONSTS_SVH

// ****************************************
// Ethernet framing bytes
// ****************************************

// Repeated seven times ahead of the SFD
`define RGMII_PREAMBLE 8'h55

// Start-of-frame delimiter, the last byte before the destination address
`define RGMII_SFD 8'hD5

// ****************************************
// FCS and length
// ****************************************

// IEEE 802.3 polynomial in bit-reversed form, shifted out LSB first
`define CRC32_POLY 32'hEDB88320

// Register value left once a good frame and its FCS have been shifted in
`define CRC32_RESIDUE 32'hDEBB20E3

`define FRAME_LEN_W 16 // Enough for jumbo frames

`endif
